/* verilog/id_pkg.sv */
package id_pkg;

   //////////////////////////////////////////////////
   // Widths fixed by the instruction set
   //////////////////////////////////////////////////

   localparam int NB_REG      = 32;
   localparam int NB_REG_ADDR = 5;
   localparam int NB_INM      = 16;
   localparam int NB_SHAMT    = 5;
   localparam int NB_J_INM    = 26;
   localparam int NB_OPCODE   = 6;
   localparam int NB_FUNC     = 6;
   localparam int NB_ALU_OP   = 4;

   // Link register for JAL
   localparam logic [NB_REG_ADDR-1:0] RA_REG = 5'd31;

   // Memory access size
   localparam logic [1:0] DSIZE_BYTE = 2'b00;
   localparam logic [1:0] DSIZE_HALF = 2'b01;
   localparam logic [1:0] DSIZE_WORD = 2'b10;

   //////////////////////////////////////////////////
   // Opcode, function and ALU encodings
   //////////////////////////////////////////////////

   typedef enum logic [NB_OPCODE-1:0] {
      R_INST = 6'b000000,
      LB     = 6'b100000,
      LH     = 6'b100001,
      LW     = 6'b100011,
      LBU    = 6'b100100,
      LHU    = 6'b100101,
      LWU    = 6'b100111,
      SB     = 6'b101000,
      SH     = 6'b101001,
      SW     = 6'b101011,
      ADDI   = 6'b001001,
      ANDI   = 6'b001100,
      ORI    = 6'b001101,
      XORI   = 6'b001110,
      LUI    = 6'b001111,
      SLTI   = 6'b001010,
      BEQ    = 6'b000100,
      BNE    = 6'b000101,
      J      = 6'b000010,
      JAL    = 6'b000011,
      HLT    = 6'b111111
   } opcode_e;

   typedef enum logic [NB_FUNC-1:0] {
      FUNC_SLL  = 6'b000000,
      FUNC_SRL  = 6'b000010,
      FUNC_SRA  = 6'b000011,
      FUNC_SLLV = 6'b000100,
      FUNC_SRLV = 6'b000110,
      FUNC_SRAV = 6'b000111,
      FUNC_ADDU = 6'b100001,
      FUNC_SUBU = 6'b100011,
      FUNC_AND  = 6'b100100,
      FUNC_OR   = 6'b100101,
      FUNC_XOR  = 6'b100110,
      FUNC_NOR  = 6'b100111,
      FUNC_SLT  = 6'b101010,
      FUNC_JR   = 6'b001000,
      FUNC_JALR = 6'b001001
   } func_e;

   typedef enum logic [NB_ALU_OP-1:0] {
      ADD    = 4'b0000,
      SUB    = 4'b0001,
      AND    = 4'b0010,
      OR     = 4'b0011,
      XOR    = 4'b0100,
      NOR    = 4'b0101,
      SRL    = 4'b0110,
      SLL    = 4'b0111,
      SRA    = 4'b1000,
      SLA    = 4'b1001,
      SLT    = 4'b1010,
      LUI_OP = 4'b1011
   } alu_op_e;

   //////////////////////////////////////////////////
   // Control words and port bundles
   //////////////////////////////////////////////////

   typedef struct packed {
      alu_op_e alu_op;
      logic    b_i;
      logic    s_u;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic       re;
      logic       we;
      logic       s_u;
      logic [1:0] dsize;
   } mem_ctrl_t;

   typedef struct packed {
      logic [NB_REG_ADDR-1:0] dest;
      logic                   reg_we;
      logic                   mem_alu;
      logic                   data_pc;
   } wb_ctrl_t;

   typedef struct packed {
      ex_ctrl_t  ex;
      mem_ctrl_t mem;
      wb_ctrl_t  wb;
      logic      is_branch;
      logic      bne;
      logic      jump_inm;
      logic      jump_rs;
      logic      rinst;
   } dec_ctrl_t;

   typedef struct packed {
      logic                   we;
      logic [NB_REG_ADDR-1:0] addr;
      logic [NB_REG-1:0]      data;
   } rf_wr_t;

   typedef struct packed {
      logic              sel_a;
      logic              sel_b;
      logic [NB_REG-1:0] data_a;
      logic [NB_REG-1:0] data_b;
   } fwd_t;

endpackage

/* verilog/id_control_decode.sv */
`timescale 1ns/1ps

module id_control_decode import id_pkg::*; (
   input  opcode_e                i_opcode,
   input  func_e                  i_func,
   input  logic [NB_REG_ADDR-1:0] i_rt,
   input  logic [NB_REG_ADDR-1:0] i_rd,
   output dec_ctrl_t              o_ctrl
);

   dec_ctrl_t              main;
   logic                   to_ra;
   alu_op_e                f_alu_op;
   logic                   f_shamt;
   logic                   f_data_pc;
   logic                   f_jump_rs;
   logic                   f_known;
   logic [NB_REG_ADDR-1:0] dest;

   //////////////////////////////////////////////////
   // Main table
   //////////////////////////////////////////////////

   always_comb begin
      main  = '0;
      to_ra = 1'b0;
      case (i_opcode)
         R_INST: begin
            main.rinst      = 1'b1;
            main.wb.reg_we  = 1'b1;
            main.wb.mem_alu = 1'b1;
         end
         LB, LH, LW, LBU, LHU, LWU: begin
            main.ex.b_i    = 1'b1;
            main.mem.re    = 1'b1;
            main.mem.s_u   = i_opcode inside {LBU, LHU, LWU};
            main.wb.reg_we = 1'b1;
         end
         SB, SH, SW: begin
            main.ex.b_i = 1'b1;
            main.mem.we = 1'b1;
         end
         ADDI, SLTI, ANDI, ORI, XORI, LUI: begin
            main.ex.b_i     = 1'b1;
            // Logic ops and LUI zero extend
            main.ex.s_u     = i_opcode inside {ANDI, ORI, XORI, LUI};
            main.wb.reg_we  = 1'b1;
            main.wb.mem_alu = 1'b1;
         end
         BEQ, BNE: begin
            main.ex.b_i     = 1'b1;
            main.is_branch  = 1'b1;
            main.bne        = (i_opcode == BNE);
         end
         J: begin
            main.jump_inm = 1'b1;
         end
         JAL: begin
            main.jump_inm   = 1'b1;
            to_ra           = 1'b1;
            main.wb.reg_we  = 1'b1;
            main.wb.data_pc = 1'b1;
         end
         default: begin
            main = '0;
         end
      endcase

      case (i_opcode)
         ADDI:    main.ex.alu_op = ADD;
         SLTI:    main.ex.alu_op = SLT;
         ANDI:    main.ex.alu_op = AND;
         ORI:     main.ex.alu_op = OR;
         XORI:    main.ex.alu_op = XOR;
         LUI:     main.ex.alu_op = LUI_OP;
         default: main.ex.alu_op = ADD;
      endcase

      case (i_opcode)
         LB, LBU, SB: main.mem.dsize = DSIZE_BYTE;
         LH, LHU, SH: main.mem.dsize = DSIZE_HALF;
         LW, LWU, SW: main.mem.dsize = DSIZE_WORD;
         default:     main.mem.dsize = DSIZE_BYTE;
      endcase
   end

   //////////////////////////////////////////////////
   // Function code table
   //////////////////////////////////////////////////

   always_comb begin
      f_known = 1'b1;
      case (i_func)
         FUNC_SLL, FUNC_SLLV:  f_alu_op = SLL;
         FUNC_SRL, FUNC_SRLV:  f_alu_op = SRL;
         FUNC_SRA, FUNC_SRAV:  f_alu_op = SRA;
         FUNC_ADDU:            f_alu_op = ADD;
         FUNC_SUBU:            f_alu_op = SUB;
         FUNC_AND:             f_alu_op = AND;
         FUNC_OR:              f_alu_op = OR;
         FUNC_XOR:             f_alu_op = XOR;
         FUNC_NOR:             f_alu_op = NOR;
         FUNC_SLT:             f_alu_op = SLT;
         FUNC_JR, FUNC_JALR:   f_alu_op = ADD;
         default: begin
            f_alu_op = ADD;
            f_known  = 1'b0;
         end
      endcase
      f_shamt   = i_func inside {FUNC_SLL, FUNC_SRL, FUNC_SRA};
      f_jump_rs = i_func inside {FUNC_JR, FUNC_JALR};
      f_data_pc = (i_func == FUNC_JALR);
   end

   // JAL links to r31 and I-type writes rt
   assign dest = to_ra ? RA_REG : (main.ex.b_i ? i_rt : i_rd);

   always_comb begin
      o_ctrl = main;
      if (main.rinst) begin
         o_ctrl.ex.alu_op    = f_alu_op;
         o_ctrl.ex.use_shamt = f_shamt;
         o_ctrl.wb.data_pc   = f_data_pc;
         o_ctrl.jump_rs      = f_jump_rs;
      end
      o_ctrl.wb.dest   = dest;
      o_ctrl.wb.reg_we = main.wb.reg_we && (dest != '0);
      if (main.rinst && !f_known) begin
         o_ctrl = '0;
      end
   end

endmodule

/* verilog/id_regfile.sv */
`timescale 1ns/1ps

module id_regfile import id_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic                   i_en,
   input  rf_wr_t                 i_wr,
   input  logic [NB_REG_ADDR-1:0] i_rs,
   input  logic [NB_REG_ADDR-1:0] i_rt,
   output logic [NB_REG-1:0]      o_rd_a,
   output logic [NB_REG-1:0]      o_rd_b
);

   localparam int DEPTH = 1 << NB_REG_ADDR;

   logic [NB_REG-1:0] regs [DEPTH];
   logic              wr_go;

   assign wr_go = i_en && i_wr.we;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int k = 0; k < DEPTH; k++) begin
            regs[k] <= '0;
         end
      end else if (wr_go) begin
         regs[i_wr.addr] <= i_wr.data;
      end
   end

   // Write-through so a same cycle read sees the write-back value
   assign o_rd_a = (wr_go && (i_wr.addr == i_rs)) ? i_wr.data : regs[i_rs];
   assign o_rd_b = (wr_go && (i_wr.addr == i_rt)) ? i_wr.data : regs[i_rt];

   a_wr_addr_known: assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_wr.we |-> !$isunknown(i_wr.addr)
   ) else $error("register file write with unknown address");

endmodule

/* verilog/id_branch_resolve.sv */
`timescale 1ns/1ps

module id_branch_resolve import id_pkg::*; (
   input  dec_ctrl_t             i_ctrl,
   input  logic [NB_REG-1:0]     i_rd_a,
   input  logic [NB_REG-1:0]     i_rd_b,
   input  fwd_t                  i_fwd,
   input  logic [NB_J_INM-1:0]   i_j_index,
   output logic                  o_branch,
   output logic                  o_branch_result,
   output logic                  o_jump_rs,
   output logic [NB_REG-1:0]     o_jump_rs_addr,
   output logic                  o_jump_inm,
   output logic [NB_J_INM-1:0]   o_jump_inm_addr,
   output logic                  o_take
);

   logic [NB_REG-1:0] cmp_a;
   logic [NB_REG-1:0] cmp_b;
   logic              equal;
   logic              outcome;

   // Operands from later stages override the register file
   assign cmp_a = i_fwd.sel_a ? i_fwd.data_a : i_rd_a;
   assign cmp_b = i_fwd.sel_b ? i_fwd.data_b : i_rd_b;

   assign equal   = (cmp_a == cmp_b);
   assign outcome = i_ctrl.bne ? !equal : equal;

   assign o_branch        = i_ctrl.is_branch;
   assign o_branch_result = i_ctrl.is_branch && outcome;

   assign o_jump_rs       = i_ctrl.jump_rs;
   assign o_jump_rs_addr  = i_rd_a;
   assign o_jump_inm      = i_ctrl.jump_inm;
   assign o_jump_inm_addr = i_j_index;

   // Next instruction gets squashed
   assign o_take = o_branch_result || i_ctrl.jump_rs || i_ctrl.jump_inm;

endmodule

/* verilog/id_stage_reg.sv */
`timescale 1ns/1ps

module id_stage_reg import id_pkg::*; (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_en,
   input  logic [NB_REG-1:0]    i_pc,
   input  logic [NB_REG-1:0]    i_rd_a,
   input  logic [NB_REG-1:0]    i_rd_b,
   input  logic [NB_INM-1:0]    i_inm,
   input  logic [NB_SHAMT-1:0]  i_shamt,
   input  dec_ctrl_t            i_ctrl,
   input  logic                 i_take,
   output logic [NB_REG-1:0]    o_pc,
   output logic [NB_REG-1:0]    o_a,
   output logic [NB_REG-1:0]    o_b,
   output logic [NB_INM-1:0]    o_inm,
   output logic [NB_SHAMT-1:0]  o_shamt,
   output ex_ctrl_t             o_ex,
   output mem_ctrl_t            o_mem,
   output wb_ctrl_t             o_wb,
   output logic                 o_nop
);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_pc    <= '0;
         o_a     <= '0;
         o_b     <= '0;
         o_inm   <= '0;
         o_shamt <= '0;
         o_ex    <= '0;
         o_mem   <= '0;
         o_wb    <= '0;
         o_nop   <= 1'b0;
      end else if (i_en) begin
         o_pc    <= i_pc;
         o_a     <= i_rd_a;
         o_b     <= i_rd_b;
         o_inm   <= i_inm;
         o_shamt <= i_shamt;
         o_ex    <= i_ctrl.ex;
         o_mem   <= i_ctrl.mem;
         o_wb    <= i_ctrl.wb;
         // Squash flag for the instruction behind a taken branch or jump
         o_nop   <= i_take;
      end
   end

   // r0 writes are dropped in the decoder
   a_no_r0_write: assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_wb.reg_we |-> (o_wb.dest != '0)
   ) else $error("write-back control targets r0");

endmodule

/* verilog/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode import id_pkg::*; (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_valid,
   input  logic [NB_REG-1:0]    i_instruction,
   input  logic [NB_REG-1:0]    i_pc,
   input  rf_wr_t               i_wr,
   input  fwd_t                 i_fwd,
   output logic                 o_run,
   output logic                 o_branch,
   output logic                 o_branch_result,
   output logic                 o_jump_rs,
   output logic [NB_REG-1:0]    o_jump_rs_addr,
   output logic                 o_jump_inm,
   output logic [NB_J_INM-1:0]  o_jump_inm_addr,
   output logic                 o_rinst,
   output logic                 o_store,
   output logic [NB_REG-1:0]    o_pc,
   output logic [NB_REG-1:0]    o_a,
   output logic [NB_REG-1:0]    o_b,
   output logic [NB_INM-1:0]    o_inm,
   output logic [NB_SHAMT-1:0]  o_shamt,
   output ex_ctrl_t             o_ex,
   output mem_ctrl_t            o_mem,
   output wb_ctrl_t             o_wb,
   output logic                 o_nop
);

   opcode_e                opcode;
   func_e                  func;
   logic [NB_REG_ADDR-1:0] rs;
   logic [NB_REG_ADDR-1:0] rt;
   logic [NB_REG_ADDR-1:0] rd;
   logic [NB_INM-1:0]      inm;
   logic [NB_SHAMT-1:0]    shamt;
   logic [NB_J_INM-1:0]    j_index;
   logic                   run;
   dec_ctrl_t              ctrl;
   logic [NB_REG-1:0]      rd_a;
   logic [NB_REG-1:0]      rd_b;
   logic                   take;

   //////////////////////////////////////////////////
   // Instruction fields
   //////////////////////////////////////////////////

   assign opcode  = opcode_e'(i_instruction[NB_REG-1 -: NB_OPCODE]);
   assign rs      = i_instruction[25 -: NB_REG_ADDR];
   assign rt      = i_instruction[20 -: NB_REG_ADDR];
   assign rd      = i_instruction[15 -: NB_REG_ADDR];
   assign shamt   = i_instruction[10 -: NB_SHAMT];
   assign func    = func_e'(i_instruction[NB_FUNC-1:0]);
   assign inm     = i_instruction[NB_INM-1:0];
   assign j_index = i_instruction[NB_J_INM-1:0];

   // Stage freezes on HLT or no valid instruction
   assign run   = i_valid && (opcode != HLT);
   assign o_run = run;

   assign o_rinst = ctrl.rinst;
   assign o_store = ctrl.mem.we;

   id_control_decode u_control_decode (
      .i_opcode (opcode),
      .i_func   (func),
      .i_rt     (rt),
      .i_rd     (rd),
      .o_ctrl   (ctrl)
   );

   id_regfile u_regfile (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_en   (run),
      .i_wr   (i_wr),
      .i_rs   (rs),
      .i_rt   (rt),
      .o_rd_a (rd_a),
      .o_rd_b (rd_b)
   );

   id_branch_resolve u_branch_resolve (
      .i_ctrl          (ctrl),
      .i_rd_a          (rd_a),
      .i_rd_b          (rd_b),
      .i_fwd           (i_fwd),
      .i_j_index       (j_index),
      .o_branch        (o_branch),
      .o_branch_result (o_branch_result),
      .o_jump_rs       (o_jump_rs),
      .o_jump_rs_addr  (o_jump_rs_addr),
      .o_jump_inm      (o_jump_inm),
      .o_jump_inm_addr (o_jump_inm_addr),
      .o_take          (take)
   );

   id_stage_reg u_stage_reg (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_en    (run),
      .i_pc    (i_pc),
      .i_rd_a  (rd_a),
      .i_rd_b  (rd_b),
      .i_inm   (inm),
      .i_shamt (shamt),
      .i_ctrl  (ctrl),
      .i_take  (take),
      .o_pc    (o_pc),
      .o_a     (o_a),
      .o_b     (o_b),
      .o_inm   (o_inm),
      .o_shamt (o_shamt),
      .o_ex    (o_ex),
      .o_mem   (o_mem),
      .o_wb    (o_wb),
      .o_nop   (o_nop)
   );

endmodule

/* sim/tb_decode_model.svh */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

//////////////////////////////////////////////////
// Reference decode and register file model
//////////////////////////////////////////////////

typedef struct packed {
   logic [31:0] pc;
   logic [31:0] a;
   logic [31:0] b;
   logic [15:0] inm;
   logic [4:0]  shamt;
   ex_ctrl_t    ex;
   mem_ctrl_t   mem;
   wb_ctrl_t    wb;
   logic        nop;
} stage_t;

logic [31:0] model_rf [32];
logic [31:0] lfsr_state = 32'd43;

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
         lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      end else begin
         lfsr_state = lfsr_state >> 1;
      end
   end
   return r;
endfunction

// Same cycle write-back is visible to the read
function automatic logic [31:0] rf_read(input logic [4:0] a, input logic en, input rf_wr_t wr);
   if (en && wr.we && wr.addr == a) begin
      return wr.data;
   end
   return model_rf[a];
endfunction

function automatic dec_ctrl_t decode_ref(input logic [31:0] ins);
   dec_ctrl_t c;
   opcode_e   op;
   c = '0;
   op = opcode_e'(ins[31:26]);
   c.wb.dest = ins[15:11];
   case (op)
      LB, LBU, SB: c.mem.dsize = 2'b00;
      LH, LHU, SH: c.mem.dsize = 2'b01;
      LW, LWU, SW: c.mem.dsize = 2'b10;
      default:     c.mem.dsize = 2'b00;
   endcase
   case (op)
      R_INST: begin
         c.rinst = 1'b1;
         c.wb.reg_we = 1'b1;
         c.wb.mem_alu = 1'b1;
      end
      LB, LH, LW, LBU, LHU, LWU: begin
         c.ex.b_i = 1'b1;
         c.mem.re = 1'b1;
         c.mem.s_u = (op == LBU) || (op == LHU) || (op == LWU);
         c.wb.reg_we = 1'b1;
      end
      SB, SH, SW: begin
         c.ex.b_i = 1'b1;
         c.mem.we = 1'b1;
      end
      ADDI, SLTI, ANDI, ORI, XORI, LUI: begin
         c.ex.b_i = 1'b1;
         c.ex.s_u = (op == ANDI) || (op == ORI) || (op == XORI) || (op == LUI);
         c.wb.reg_we = 1'b1;
         c.wb.mem_alu = 1'b1;
         c.ex.alu_op = (op == SLTI) ? SLT : (op == ANDI) ? AND : (op == ORI) ? OR :
                       (op == XORI) ? XOR : (op == LUI) ? LUI_OP : ADD;
      end
      BEQ, BNE: begin
         c.ex.b_i = 1'b1;
         c.is_branch = 1'b1;
         c.bne = (op == BNE);
      end
      J: c.jump_inm = 1'b1;
      JAL: begin
         c.jump_inm = 1'b1;
         c.wb.reg_we = 1'b1;
         c.wb.data_pc = 1'b1;
         c.wb.dest = 5'd31;
      end
      default: c.ex.b_i = 1'b0;
   endcase
   if (c.ex.b_i) begin
      c.wb.dest = ins[20:16];
   end
   if (c.rinst) begin
      case (func_e'(ins[5:0]))
         FUNC_SLL:  {c.ex.alu_op, c.ex.use_shamt} = {SLL, 1'b1};
         FUNC_SRL:  {c.ex.alu_op, c.ex.use_shamt} = {SRL, 1'b1};
         FUNC_SRA:  {c.ex.alu_op, c.ex.use_shamt} = {SRA, 1'b1};
         FUNC_SLLV: c.ex.alu_op = SLL;
         FUNC_SRLV: c.ex.alu_op = SRL;
         FUNC_SRAV: c.ex.alu_op = SRA;
         FUNC_ADDU: c.ex.alu_op = ADD;
         FUNC_SUBU: c.ex.alu_op = SUB;
         FUNC_AND:  c.ex.alu_op = AND;
         FUNC_OR:   c.ex.alu_op = OR;
         FUNC_XOR:  c.ex.alu_op = XOR;
         FUNC_NOR:  c.ex.alu_op = NOR;
         FUNC_SLT:  c.ex.alu_op = SLT;
         FUNC_JR:   c.jump_rs = 1'b1;
         FUNC_JALR: {c.jump_rs, c.wb.data_pc} = 2'b11;
         default:   c = '0;
      endcase
   end
   if (c.wb.dest == 5'd0) begin
      c.wb.reg_we = 1'b0;
   end
   return c;
endfunction

`endif

/* sim/tb_instruction_decode.sv */
`timescale 1ns/1ps

module tb_instruction_decode import id_pkg::*;;

   `include "tb_decode_model.svh"

   localparam int TOTAL_CYCLES = 5 + 32 + 32 + 32 + 8 + 200 + 32 + 16 + 12 + 4;
   localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES;

   logic        i_clk;
   logic        i_rst;
   logic        i_valid;
   logic [31:0] i_instruction;
   logic [31:0] i_pc;
   rf_wr_t      i_wr;
   fwd_t        i_fwd;
   logic        o_run;
   logic        o_branch;
   logic        o_branch_result;
   logic        o_jump_rs;
   logic [31:0] o_jump_rs_addr;
   logic        o_jump_inm;
   logic [25:0] o_jump_inm_addr;
   logic        o_rinst;
   logic        o_store;
   logic [31:0] o_pc;
   logic [31:0] o_a;
   logic [31:0] o_b;
   logic [15:0] o_inm;
   logic [4:0]  o_shamt;
   ex_ctrl_t    o_ex;
   mem_ctrl_t   o_mem;
   wb_ctrl_t    o_wb;
   logic        o_nop;

   string       test_name = "reset";
   logic [31:0] pc_cnt = '0;
   int          cycles = 0;

   instruction_decode i_instruction_decode (.*);

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   initial begin
      forever begin
         @(posedge i_clk);
         cycles++;
         if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
         end
      end
   end

   task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else begin
         $display("Error %s %s expected %h actual %h", test_name, what, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] fn);
      return {6'b0, rs, rt, rd, 5'(rand_bits(5)), fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt);
      return {op, rs, rt, 16'(rand_bits(16))};
   endfunction

   task automatic drive(input logic v, input logic [31:0] ins, input rf_wr_t wr, input fwd_t fw);
      @(negedge i_clk);
      i_valid = v;
      i_instruction = ins;
      i_pc = pc_cnt;
      pc_cnt += 32'd4;
      i_wr = wr;
      i_fwd = fw;
   endtask

   //////////////////////////////////////////////////
   // Comparison
   //////////////////////////////////////////////////

   initial begin : compare
      stage_t      nxt;
      dec_ctrl_t   c;
      logic        run;
      logic [31:0] ra;
      logic [31:0] rb;
      logic        res;
      nxt = '0;
      forever begin
         @(negedge i_clk);
         #3;
         if (i_rst) begin
            nxt = '0;
            for (int k = 0; k < 32; k++) begin
               model_rf[k] = '0;
            end
         end else begin
            c = decode_ref(i_instruction);
            run = i_valid && (i_instruction[31:26] != 6'b111111);
            ra = rf_read(i_instruction[25:21], run, i_wr);
            rb = rf_read(i_instruction[20:16], run, i_wr);
            res = ((i_fwd.sel_a ? i_fwd.data_a : ra) == (i_fwd.sel_b ? i_fwd.data_b : rb));
            res = c.is_branch && (c.bne ? !res : res);
            check("o_run", 64'(run), 64'(o_run));
            check("o_branch", 64'(c.is_branch), 64'(o_branch));
            check("o_branch_result", 64'(res), 64'(o_branch_result));
            check("o_jump_rs", 64'(c.jump_rs), 64'(o_jump_rs));
            check("o_jump_rs_addr", 64'(ra), 64'(o_jump_rs_addr));
            check("o_jump_inm", 64'(c.jump_inm), 64'(o_jump_inm));
            check("o_jump_inm_addr", 64'(i_instruction[25:0]), 64'(o_jump_inm_addr));
            check("o_rinst", 64'(c.rinst), 64'(o_rinst));
            check("o_store", 64'(c.mem.we), 64'(o_store));
            if (run) begin
               nxt = {i_pc, ra, rb, i_instruction[15:0], i_instruction[10:6], c.ex, c.mem, c.wb,
                      res || c.jump_rs || c.jump_inm};
               if (i_wr.we) begin
                  model_rf[i_wr.addr] = i_wr.data;
               end
            end
         end
         @(posedge i_clk);
         #1;
         check("o_pc", 64'(nxt.pc), 64'(o_pc));
         check("o_a", 64'(nxt.a), 64'(o_a));
         check("o_b", 64'(nxt.b), 64'(o_b));
         check("o_inm", 64'(nxt.inm), 64'(o_inm));
         check("o_shamt", 64'(nxt.shamt), 64'(o_shamt));
         check("o_ex", 64'(nxt.ex), 64'(o_ex));
         check("o_mem", 64'(nxt.mem), 64'(o_mem));
         check("o_wb", 64'(nxt.wb), 64'(o_wb));
         check("o_nop", 64'(nxt.nop), 64'(o_nop));
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin : stimulus
      logic [5:0]  op_tab [24];
      logic [5:0]  fn_tab [17];
      logic [5:0]  op;
      logic [5:0]  fn;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [31:0] va;
      rf_wr_t      wr;
      fwd_t        fw;
      op_tab = '{R_INST, LB, LH, LW, LBU, LHU, LWU, SB, SH, SW, ADDI, ANDI, ORI, XORI, LUI,
                 SLTI, BEQ, BNE, J, JAL, HLT, 6'h01, 6'h10, 6'h3e};
      fn_tab = '{FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV, FUNC_SRAV, FUNC_ADDU,
                 FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_JR,
                 FUNC_JALR, 6'h01, 6'h3f};
      i_rst = 1'b1;
      i_valid = 1'b0;
      i_instruction = '0;
      i_pc = '0;
      i_wr = '0;
      i_fwd = '0;
      repeat (5) @(negedge i_clk);
      i_rst = 1'b0;

      test_name = "reset_read";
      for (int k = 0; k < 32; k++) begin
         drive(1'b1, enc_r(5'(k), 5'(k), 5'(k), FUNC_ADDU), '0, '0);
      end

      test_name = "rf_fill";
      for (int k = 0; k < 32; k++) begin
         drive(1'b1, enc_r(5'd0, 5'd0, 5'd0, FUNC_ADDU), {1'b1, 5'(k), rand_bits(32)}, '0);
      end

      test_name = "rf_read";
      for (int k = 0; k < 32; k++) begin
         drive(1'b1, enc_r(5'(rand_bits(5)), 5'(rand_bits(5)), 5'd1, FUNC_OR), '0, '0);
      end

      test_name = "write_through";
      for (int k = 0; k < 8; k++) begin
         rs = 5'(rand_bits(5));
         drive(1'b1, enc_r(rs, k[0] ? rs : 5'(rand_bits(5)), 5'd2, FUNC_ADDU),
               {1'b1, rs, rand_bits(32)}, '0);
      end

      test_name = "control";
      for (int k = 0; k < 200; k++) begin
         op = op_tab[rand_bits(8) % 24];
         fn = fn_tab[rand_bits(8) % 17];
         wr = {1'(rand_bits(1)), 5'(rand_bits(5)), rand_bits(32)};
         fw = {2'(rand_bits(2)), rand_bits(32), rand_bits(32)};
         drive(rand_bits(3) != 0, {op, 20'(rand_bits(20)), fn}, wr, fw);
      end

      test_name = "branch";
      for (int k = 0; k < 16; k++) begin
         rs = 5'(rand_bits(5));
         rt = rs + 5'd1;
         fw = {k[1], k[2], rand_bits(32), rand_bits(32)};
         va = fw.sel_a ? fw.data_a : model_rf[rs];
         if (k[3]) begin
            // Force equal operands
            if (fw.sel_b) fw.data_b = va;
            else if (fw.sel_a) fw.data_a = model_rf[rt];
            else rt = rs;
         end else if (fw.sel_b) begin
            fw.data_b = ~va;
         end else if (fw.sel_a) begin
            fw.data_a = ~model_rf[rt];
         end
         drive(1'b1, enc_i(k[0] ? BNE : BEQ, rs, rt), '0, fw);
         drive(1'b1, enc_r(5'd3, 5'd4, 5'd5, FUNC_ADDU), '0, '0);
      end

      test_name = "jump";
      for (int k = 0; k < 8; k++) begin
         case (k % 4)
            0: drive(1'b1, {J, 26'(rand_bits(26))}, '0, '0);
            1: drive(1'b1, {JAL, 26'(rand_bits(26))}, '0, '0);
            2: drive(1'b1, enc_r(5'(rand_bits(5)), 5'd0, 5'd0, FUNC_JR), '0, '0);
            default: drive(1'b1, enc_r(5'(rand_bits(5)), 5'd0, 5'd31, FUNC_JALR), '0, '0);
         endcase
         drive(1'b1, enc_r(5'd6, 5'd7, 5'd8, FUNC_SUBU), '0, '0);
      end

      test_name = "halt";
      for (int k = 0; k < 4; k++) begin
         rs = 5'(rand_bits(5));
         rt = 5'(rand_bits(5));
         drive(1'b0, enc_i(ADDI, 5'd1, 5'd2), {1'b1, rs, rand_bits(32)}, '0);
         drive(1'b1, {HLT, 26'(rand_bits(26))}, {1'b1, rt, rand_bits(32)}, '0);
         drive(1'b1, enc_r(rs, rt, 5'd9, FUNC_XOR), '0, '0);
      end

      test_name = "drain";
      repeat (4) drive(1'b0, '0, '0, '0);
      @(posedge i_clk);
      #2;
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+sim
verilog/id_pkg.sv
verilog/id_control_decode.sv
verilog/id_regfile.sv
verilog/id_branch_resolve.sv
verilog/id_stage_reg.sv
verilog/instruction_decode.sv
sim/tb_instruction_decode.sv

/* Makefile */
SIM  := obj_dir/Vtb_instruction_decode
SRCS := $(filter-out +%,$(shell cat verilog.f)) sim/tb_decode_model.svh

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f \
		--top-module tb_instruction_decode -o Vtb_instruction_decode

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
